/* memTestPkg.sv */
/*
  Memory test kernel definitions: data widths, parameter register
  offsets, the pass pattern step and the test configuration record.
*/
`default_nettype none

package memTestPkg;

  typedef logic [63:0] addrT;
  typedef logic [63:0] dataT;
  typedef logic [31:0] wordT;
  typedef logic [31:0] regOffsetT;

  // Parameter register file offsets, fetched in this order.
  localparam regOffsetT OffsetMemBaseLo = 32'h40;
  localparam regOffsetT OffsetMemBaseHi = 32'h44;
  localparam regOffsetT OffsetBlockSize = 32'h48;
  localparam regOffsetT OffsetTestCount = 32'h4C;
  localparam regOffsetT OffsetResultLo  = 32'h50;
  localparam regOffsetT OffsetResultHi  = 32'h54;

  // Seed of pass p is p times this odd step.
  localparam dataT PatternStep = 64'h9E37_79B9_7F4A_7C15;

  typedef struct packed {
    addrT baseAddr;
    wordT blockLength;
    wordT passCount;
    addrT resultAddr;
  } testConfigT;

endpackage

`default_nettype wire

/* memBusPkg.sv */
/*
  Memory port and control slave records shared by the kernel blocks.
*/
`default_nettype none

package memBusPkg;

  // Single word request, write flag high for a store.
  typedef struct packed {
    logic             write;
    memTestPkg::addrT addr;
    memTestPkg::dataT data;
  } memReqT;

  // Read data, meaningless for a write response.
  typedef struct packed {
    memTestPkg::dataT data;
  } memRespT;

  typedef struct packed {
    memTestPkg::wordT data;
    logic [1:0]       resp;
  } slaveReadT;

endpackage

`default_nettype wire

/* paramFetcher.sv */
/*
  Kernel sequencer. Waits for go, fetches the six parameter words,
  launches the tester, has the error count written and reports done.
*/
`timescale 1ns/1ns
`default_nettype none

module paramFetcher (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   goReady,
  output logic                   goStop,
  output logic                   doneReady,
  input  logic                   doneStop,
  output logic                   paramAddrReady,
  output memTestPkg::regOffsetT  paramAddrData,
  input  logic                   paramAddrStop,
  input  logic                   paramDataReady,
  input  memTestPkg::wordT       paramDataData,
  output logic                   paramDataStop,
  output logic                   cfgValid,
  output memTestPkg::testConfigT cfg,
  input  logic                   cfgStop,
  input  logic                   statusValid,
  input  memTestPkg::wordT       errorCount,
  output logic                   statusStop,
  output logic                   writeValid,
  input  logic                   writeStop,
  input  logic                   writeDoneValid,
  output logic                   writeDoneStop,
  output memTestPkg::wordT       errorCountReg
);
  import memTestPkg::*;

  typedef enum logic [3:0] {
    Boot, Idle, ParamAddr, ParamData, Launch,
    WaitStatus, WriteReq, WriteWait, Report
  } stateT;

  stateT      state;
  logic [2:0] paramIdx;
  testConfigT cfgReg;

  // Offset of the parameter word being fetched.
  always_comb
  begin
    case (paramIdx)
      3'd0:    paramAddrData = OffsetMemBaseLo;
      3'd1:    paramAddrData = OffsetMemBaseHi;
      3'd2:    paramAddrData = OffsetBlockSize;
      3'd3:    paramAddrData = OffsetTestCount;
      3'd4:    paramAddrData = OffsetResultLo;
      default: paramAddrData = OffsetResultHi;
    endcase
  end

  assign goStop         = (state != Idle);
  assign doneReady      = (state == Report);
  assign paramAddrReady = (state == ParamAddr);
  assign paramDataStop  = (state != ParamData);
  assign cfgValid       = (state == Launch);
  assign statusStop     = (state != WaitStatus);
  assign writeValid     = (state == WriteReq);
  assign writeDoneStop  = (state != WriteWait);
  assign cfg            = cfgReg;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state         <= Boot;
      paramIdx      <= '0;
      errorCountReg <= '0;
    end
    else
    begin
      case (state)
        Boot:
          state <= Idle;
        Idle:
          if (goReady)
          begin
            errorCountReg <= '0;
            paramIdx      <= '0;
            state         <= ParamAddr;
          end
        ParamAddr:
          if (!paramAddrStop)
            state <= ParamData;
        ParamData:
          if (paramDataReady)
          begin
            paramIdx <= paramIdx + 3'd1;
            state    <= (paramIdx == 3'd5) ? Launch : ParamAddr;
          end
        Launch:
          if (!cfgStop)
            state <= WaitStatus;
        WaitStatus:
          if (statusValid)
          begin
            errorCountReg <= errorCount;
            state         <= WriteReq;
          end
        WriteReq:
          if (!writeStop)
            state <= WriteWait;
        WriteWait:
          if (writeDoneValid)
            state <= Report;
        default:
          // Held here while the host keeps done stopped.
          if (!doneStop)
            state <= Idle;
      endcase
    end
  end

  // Assemble the configuration one parameter word at a time.
  always_ff @(posedge clk)
  begin
    if (state == ParamData && paramDataReady)
    begin
      case (paramIdx)
        3'd0:    cfgReg.baseAddr[31:0]    <= paramDataData;
        3'd1:    cfgReg.baseAddr[63:32]   <= paramDataData;
        3'd2:    cfgReg.blockLength       <= paramDataData;
        3'd3:    cfgReg.passCount         <= paramDataData;
        3'd4:    cfgReg.resultAddr[31:0]  <= paramDataData;
        default: cfgReg.resultAddr[63:32] <= paramDataData;
      endcase
    end
  end

endmodule

`default_nettype wire

/* patternTester.sv */
/*
  Pass engine. Each pass writes address XOR seed to every word of the
  block, then reads the block back and counts the words that differ.
*/
`timescale 1ns/1ns
`default_nettype none

module patternTester #(
  parameter int MaxOutstanding = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cfgValid,
  input  memTestPkg::testConfigT cfg,
  output logic                   cfgStop,
  output logic                   statusValid,
  output memTestPkg::wordT       errorCount,
  input  logic                   statusStop,
  output logic                   reqValid,
  output memBusPkg::memReqT      req,
  input  logic                   reqReady,
  input  logic                   respValid,
  input  memBusPkg::memRespT     resp,
  output logic                   respReady
);
  import memTestPkg::*;

  typedef enum logic [1:0] {Idle, Write, Read, Report} stateT;

  localparam int CntW = $clog2(MaxOutstanding + 1);

  stateT           state;
  testConfigT      cfgReg;
  wordT            numWords;
  wordT            passIdx;
  wordT            reqIdx;
  wordT            respIdx;
  logic [CntW-1:0] inFlight;
  dataT            seed;
  wordT            errors;
  addrT            reqAddr;
  addrT            expAddr;
  logic            active;
  logic            reqFire;
  logic            respFire;
  logic            mismatch;

  assign active  = (state == Write) || (state == Read);
  assign reqAddr = cfgReg.baseAddr + (addrT'(reqIdx) << 3);
  // Responses come back in order, so the response index names the word.
  assign expAddr = cfgReg.baseAddr + (addrT'(respIdx) << 3);

  assign reqValid  = active && (reqIdx != numWords) && (inFlight != CntW'(MaxOutstanding));
  assign req       = '{write: (state == Write), addr: reqAddr, data: reqAddr ^ seed};
  assign respReady = active;
  assign reqFire   = reqValid && reqReady;
  assign respFire  = respValid && respReady;
  assign mismatch  = (state == Read) && (resp.data != (expAddr ^ seed));

  assign cfgStop     = (state != Idle);
  assign statusValid = (state == Report);
  assign errorCount  = errors;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state    <= Idle;
      passIdx  <= '0;
      reqIdx   <= '0;
      respIdx  <= '0;
      inFlight <= '0;
      seed     <= '0;
      errors   <= '0;
    end
    else
    begin
      case (state)
        Idle:
          if (cfgValid)
          begin
            passIdx <= '0;
            reqIdx  <= '0;
            respIdx <= '0;
            seed    <= '0;
            errors  <= '0;
            // Nothing to test, so report zero without touching memory.
            if (cfg.passCount == '0 || cfg.blockLength[31:3] == '0)
              state <= Report;
            else
              state <= Write;
          end
        Write, Read:
        begin
          if (reqFire)
            reqIdx <= reqIdx + 32'd1;
          if (respFire)
            respIdx <= respIdx + 32'd1;
          if (respFire && mismatch)
            errors <= errors + 32'd1;
          inFlight <= inFlight + CntW'(reqFire) - CntW'(respFire);

          // Every response of the phase is in, nothing is left in flight.
          if (respIdx == numWords)
          begin
            reqIdx  <= '0;
            respIdx <= '0;
            if (state == Write)
              state <= Read;
            else if (passIdx + 32'd1 == cfgReg.passCount)
              state <= Report;
            else
            begin
              passIdx <= passIdx + 32'd1;
              seed    <= seed + PatternStep;
              state   <= Write;
            end
          end
        end
        default:
          if (!statusStop)
            state <= Idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == Idle && cfgValid)
    begin
      cfgReg   <= cfg;
      numWords <= cfg.blockLength >> 3;
    end
  end

endmodule

`default_nettype wire

/* statusWriter.sv */
/*
  Writes the error count, zero extended, to the result address and
  signals done once the write response has come back.
*/
`timescale 1ns/1ns
`default_nettype none

module statusWriter (
  input  logic               clk,
  input  logic               reset,
  input  logic               writeValid,
  output logic               writeStop,
  output logic               writeDoneValid,
  input  logic               writeDoneStop,
  input  memTestPkg::addrT   resultAddr,
  input  memTestPkg::wordT   errorCount,
  output logic               reqValid,
  output memBusPkg::memReqT  req,
  input  logic               reqReady,
  input  logic               respValid,
  input  memBusPkg::memRespT resp,
  output logic               respReady
);
  import memTestPkg::*;

  typedef enum logic [1:0] {Idle, Request, WaitResp, Done} stateT;

  stateT state;

  // Address and count are held steady by the sequencer during the write.
  assign req            = '{write: 1'b1, addr: resultAddr, data: dataT'(errorCount)};
  assign reqValid       = (state == Request);
  assign respReady      = (state == WaitResp);
  assign writeStop      = (state != Idle);
  assign writeDoneValid = (state == Done);

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= Idle;
    else
    begin
      case (state)
        Idle:
          if (writeValid)
            state <= Request;
        Request:
          if (reqReady)
            state <= WaitResp;
        WaitResp:
          // A write response carries no data of interest.
          if (respValid)
            state <= Done;
        default:
          if (!writeDoneStop)
            state <= Idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* memArbiter.sv */
/*
  Two client arbiter in front of the memory port. The owner keeps the
  port until its responses are all back; the status writer has priority.
*/
`timescale 1ns/1ns
`default_nettype none

module memArbiter #(
  parameter int MaxOutstanding = 4
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               testReqValid,
  input  memBusPkg::memReqT  testReq,
  output logic               testReqReady,
  output logic               testRespValid,
  output memBusPkg::memRespT testResp,
  input  logic               testRespReady,
  input  logic               statReqValid,
  input  memBusPkg::memReqT  statReq,
  output logic               statReqReady,
  output logic               statRespValid,
  output memBusPkg::memRespT statResp,
  input  logic               statRespReady,
  output logic               memReqValid,
  output memBusPkg::memReqT  memReq,
  input  logic               memReqReady,
  input  logic               memRespValid,
  input  memBusPkg::memRespT memResp,
  output logic               memRespReady
);
  localparam int CntW = $clog2(MaxOutstanding + 1);

  logic            owner;  // High while the status writer owns the port.
  logic            grant;
  logic [CntW-1:0] pending;
  logic            reqFire;
  logic            respFire;

  // Ownership may only move once no response is owed.
  always_comb
  begin
    grant = owner;
    if (pending == '0)
    begin
      if (statReqValid)
        grant = 1'b1;
      else if (testReqValid)
        grant = 1'b0;
    end
  end

  assign memReqValid  = grant ? statReqValid : testReqValid;
  assign memReq       = grant ? statReq : testReq;
  assign testReqReady = !grant && memReqReady;
  assign statReqReady = grant && memReqReady;

  assign testRespValid = !grant && memRespValid;
  assign statRespValid = grant && memRespValid;
  assign testResp      = memResp;
  assign statResp      = memResp;
  assign memRespReady  = grant ? statRespReady : testRespReady;

  assign reqFire  = memReqValid && memReqReady;
  assign respFire = memRespValid && memRespReady;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      owner   <= 1'b0;
      pending <= '0;
    end
    else
    begin
      owner   <= grant;
      pending <= pending + CntW'(reqFire) - CntW'(respFire);
    end
  end

endmodule

`default_nettype wire

/* ctrlSlaveLoopback.sv */
/*
  Control slave responder. Reads return the latest error count,
  writes are acknowledged and dropped.
*/
`timescale 1ns/1ns
`default_nettype none

module ctrlSlaveLoopback (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 ctrlArValid,
  output logic                 ctrlArReady,
  output logic                 ctrlRValid,
  output memBusPkg::slaveReadT ctrlRead,
  input  logic                 ctrlRReady,
  input  logic                 ctrlAwValid,
  input  logic                 ctrlWValid,
  output logic                 ctrlAwReady,
  output logic                 ctrlWReady,
  output logic                 ctrlBValid,
  input  logic                 ctrlBReady,
  input  memTestPkg::wordT     errorCount
);
  typedef enum logic [1:0] {AckIdle, AckAccept, AckRespond} ackStateT;

  // Channel 0 is the read path, channel 1 the write path.
  logic [1:0] reqIn;
  logic [1:0] respTaken;
  logic [1:0] accept;
  logic [1:0] respond;

  assign reqIn     = {ctrlAwValid && ctrlWValid, ctrlArValid};
  assign respTaken = {ctrlBReady, ctrlRReady};

  for (genvar ch = 0; ch < 2; ch++)
  begin : gAck
    ackStateT state;

    always_ff @(posedge clk)
    begin
      if (reset)
        state <= AckIdle;
      else
      begin
        case (state)
          AckIdle:
            if (reqIn[ch])
              state <= AckAccept;
          AckAccept:
            state <= AckRespond;
          default:
            if (respTaken[ch])
              state <= AckIdle;
        endcase
      end
    end

    assign accept[ch]  = (state == AckAccept);
    assign respond[ch] = (state == AckRespond);
  end

  assign ctrlArReady = accept[0];
  assign ctrlRValid  = respond[0];
  assign ctrlRead    = '{data: errorCount, resp: 2'b00};
  assign ctrlAwReady = accept[1];
  assign ctrlWReady  = accept[1];
  assign ctrlBValid  = respond[1];

endmodule

`default_nettype wire

/* memTestAction.sv */
/*
  Memory test kernel top level. Connects the sequencer, pattern tester,
  status writer, memory arbiter and control slave responder.
*/
`timescale 1ns/1ns
`default_nettype none

module memTestAction #(
  parameter int MaxOutstanding = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  goReady,
  output logic                  goStop,
  output logic                  doneReady,
  input  logic                  doneStop,
  output logic                  paramAddrReady,
  output memTestPkg::regOffsetT paramAddrData,
  input  logic                  paramAddrStop,
  input  logic                  paramDataReady,
  input  memTestPkg::wordT      paramDataData,
  output logic                  paramDataStop,
  output logic                  memReqValid,
  output memBusPkg::memReqT     memReq,
  input  logic                  memReqReady,
  input  logic                  memRespValid,
  input  memBusPkg::memRespT    memResp,
  output logic                  memRespReady,
  input  logic                  ctrlArValid,
  output logic                  ctrlArReady,
  output logic                  ctrlRValid,
  output memBusPkg::slaveReadT  ctrlRead,
  input  logic                  ctrlRReady,
  input  logic                  ctrlAwValid,
  input  logic                  ctrlWValid,
  output logic                  ctrlAwReady,
  output logic                  ctrlWReady,
  output logic                  ctrlBValid,
  input  logic                  ctrlBReady
);
  import memTestPkg::*;
  import memBusPkg::*;

  testConfigT cfg;
  logic       cfgValid;
  logic       cfgStop;
  logic       statusValid;
  logic       statusStop;
  wordT       testErrorCount;
  wordT       errorCountReg;
  logic       writeValid;
  logic       writeStop;
  logic       writeDoneValid;
  logic       writeDoneStop;

  // Tester and status writer sides of the arbiter.
  logic    testReqValid;
  memReqT  testReq;
  logic    testReqReady;
  logic    testRespValid;
  memRespT testResp;
  logic    testRespReady;
  logic    statReqValid;
  memReqT  statReq;
  logic    statReqReady;
  logic    statRespValid;
  memRespT statResp;
  logic    statRespReady;

  paramFetcher i_paramFetcher (
    .clk(clk), .reset(reset),
    .goReady(goReady), .goStop(goStop),
    .doneReady(doneReady), .doneStop(doneStop),
    .paramAddrReady(paramAddrReady), .paramAddrData(paramAddrData),
    .paramAddrStop(paramAddrStop),
    .paramDataReady(paramDataReady), .paramDataData(paramDataData),
    .paramDataStop(paramDataStop),
    .cfgValid(cfgValid), .cfg(cfg), .cfgStop(cfgStop),
    .statusValid(statusValid), .errorCount(testErrorCount), .statusStop(statusStop),
    .writeValid(writeValid), .writeStop(writeStop),
    .writeDoneValid(writeDoneValid), .writeDoneStop(writeDoneStop),
    .errorCountReg(errorCountReg)
  );

  patternTester #(.MaxOutstanding(MaxOutstanding)) i_patternTester (
    .clk(clk), .reset(reset),
    .cfgValid(cfgValid), .cfg(cfg), .cfgStop(cfgStop),
    .statusValid(statusValid), .errorCount(testErrorCount), .statusStop(statusStop),
    .reqValid(testReqValid), .req(testReq), .reqReady(testReqReady),
    .respValid(testRespValid), .resp(testResp), .respReady(testRespReady)
  );

  statusWriter i_statusWriter (
    .clk(clk), .reset(reset),
    .writeValid(writeValid), .writeStop(writeStop),
    .writeDoneValid(writeDoneValid), .writeDoneStop(writeDoneStop),
    .resultAddr(cfg.resultAddr), .errorCount(errorCountReg),
    .reqValid(statReqValid), .req(statReq), .reqReady(statReqReady),
    .respValid(statRespValid), .resp(statResp), .respReady(statRespReady)
  );

  memArbiter #(.MaxOutstanding(MaxOutstanding)) i_memArbiter (
    .clk(clk), .reset(reset),
    .testReqValid(testReqValid), .testReq(testReq), .testReqReady(testReqReady),
    .testRespValid(testRespValid), .testResp(testResp), .testRespReady(testRespReady),
    .statReqValid(statReqValid), .statReq(statReq), .statReqReady(statReqReady),
    .statRespValid(statRespValid), .statResp(statResp), .statRespReady(statRespReady),
    .memReqValid(memReqValid), .memReq(memReq), .memReqReady(memReqReady),
    .memRespValid(memRespValid), .memResp(memResp), .memRespReady(memRespReady)
  );

  ctrlSlaveLoopback i_ctrlSlaveLoopback (
    .clk(clk), .reset(reset),
    .ctrlArValid(ctrlArValid), .ctrlArReady(ctrlArReady),
    .ctrlRValid(ctrlRValid), .ctrlRead(ctrlRead), .ctrlRReady(ctrlRReady),
    .ctrlAwValid(ctrlAwValid), .ctrlWValid(ctrlWValid),
    .ctrlAwReady(ctrlAwReady), .ctrlWReady(ctrlWReady),
    .ctrlBValid(ctrlBValid), .ctrlBReady(ctrlBReady),
    .errorCount(errorCountReg)
  );

endmodule

`default_nettype wire

/* tbMemModel.sv */
/*
  Testbench memory model. Single word store with in order responses,
  an optional word whose bit 0 reads back inverted, and random stalls.
*/
`timescale 1ns/1ns
`default_nettype none

module tbMemModel #(
  parameter int Depth = 1024
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               faultEnable,
  input  memTestPkg::addrT   faultAddr,
  input  logic               randomDelay,
  input  logic               memReqValid,
  input  memBusPkg::memReqT  memReq,
  output logic               memReqReady,
  output logic               memRespValid,
  output memBusPkg::memRespT memResp,
  input  logic               memRespReady
);
  import memTestPkg::*;
  import memBusPkg::*;

  localparam int IdxW = $clog2(Depth);

  dataT        words [Depth];
  dataT        respQueue [$];
  logic        respPopped;
  logic        delayOn;
  logic [31:0] fillIdx;
  int          reqCount;

  // Byte address to word slot, upper address bits alias.
  function automatic int wordIndex(addrT addr);
    return int'(addr[IdxW+2:3]);
  endfunction

  function automatic dataT peek(addrT addr);
    return words[wordIndex(addr)];
  endfunction

  task automatic poke(addrT addr, dataT data);
    words[wordIndex(addr)] = data;
  endtask

  initial
  begin
    for (int i = 0; i < Depth; i++)
    begin
      fillIdx  = i;
      words[i] = {~fillIdx, fillIdx} ^ 64'hC3C3_0000_0000_3C3C;
    end
    memReqReady  = 1'b0;
    memRespValid = 1'b0;
    memResp      = '0;
    respPopped   = 1'b0;
    delayOn      = 1'b0;
    reqCount     = 0;
  end

  // Transfers are taken at the rising edge.
  always @(posedge clk)
  begin
    delayOn = randomDelay;
    if (reset)
      respQueue.delete();
    else
    begin
      if (memRespValid && memRespReady)
      begin
        void'(respQueue.pop_front());
        respPopped = 1'b1;
      end
      if (memReqValid && memReqReady)
      begin
        reqCount++;
        if (memReq.write)
        begin
          words[wordIndex(memReq.addr)] = memReq.data;
          respQueue.push_back('0);
        end
        else if (faultEnable && memReq.addr == faultAddr)
          respQueue.push_back(words[wordIndex(memReq.addr)] ^ 64'd1);
        else
          respQueue.push_back(words[wordIndex(memReq.addr)]);
      end
    end
  end

  // Outputs change at the falling edge. A shown response holds until taken.
  always @(negedge clk)
  begin
    memReqReady = !delayOn || ($urandom % 3 != 0);
    if (!memRespValid || respPopped)
    begin
      if (respQueue.size() != 0 && (!delayOn || $urandom % 3 == 0))
      begin
        memRespValid = 1'b1;
        memResp      = '{data: respQueue[0]};
      end
      else
        memRespValid = 1'b0;
    end
    respPopped = 1'b0;
  end

endmodule

`default_nettype wire

/* tbMemTestAction.sv */
/*
  Memory test kernel testbench. Serves the parameter registers, runs
  directed tests against the memory model and checks counts and contents.
*/
`timescale 1ns/1ns
`default_nettype none

module tbMemTestAction;
  import memTestPkg::*;
  import memBusPkg::*;

  localparam int   MaxOutstanding = 4;
  // Words times passes over all tests, test 5 at its largest.
  localparam int   WordPasses     = 16 * 3 + 16 * 4 + 16 * 2 + 24 * 4;
  localparam int   TimeoutCycles  = WordPasses * 20 + 3000;
  localparam dataT ResultMarker   = 64'hFFFF_FFFF_FFFF_FFFF;

  logic      clk;
  logic      reset;
  logic      goReady;
  logic      goStop;
  logic      doneReady;
  logic      doneStop;
  logic      paramAddrReady;
  regOffsetT paramAddrData;
  logic      paramAddrStop;
  logic      paramDataReady;
  wordT      paramDataData;
  logic      paramDataStop;
  logic      memReqValid;
  memReqT    memReq;
  logic      memReqReady;
  logic      memRespValid;
  memRespT   memResp;
  logic      memRespReady;
  logic      ctrlArValid;
  logic      ctrlArReady;
  logic      ctrlRValid;
  slaveReadT ctrlRead;
  logic      ctrlRReady;
  logic      ctrlAwValid;
  logic      ctrlWValid;
  logic      ctrlAwReady;
  logic      ctrlWReady;
  logic      ctrlBValid;
  logic      ctrlBReady;
  logic      faultEnable;
  addrT      faultAddr;
  logic      randomDelay;

  wordT      paramRegs [64];
  regOffsetT pendingOffset;
  wordT      lastCount;
  int        errors;
  int        checks;
  int        doneTransfers;
  int        cycleCount;

  memTestAction #(.MaxOutstanding(MaxOutstanding)) i_memTestAction (
    .clk(clk), .reset(reset),
    .goReady(goReady), .goStop(goStop), .doneReady(doneReady), .doneStop(doneStop),
    .paramAddrReady(paramAddrReady), .paramAddrData(paramAddrData),
    .paramAddrStop(paramAddrStop),
    .paramDataReady(paramDataReady), .paramDataData(paramDataData),
    .paramDataStop(paramDataStop),
    .memReqValid(memReqValid), .memReq(memReq), .memReqReady(memReqReady),
    .memRespValid(memRespValid), .memResp(memResp), .memRespReady(memRespReady),
    .ctrlArValid(ctrlArValid), .ctrlArReady(ctrlArReady),
    .ctrlRValid(ctrlRValid), .ctrlRead(ctrlRead), .ctrlRReady(ctrlRReady),
    .ctrlAwValid(ctrlAwValid), .ctrlWValid(ctrlWValid),
    .ctrlAwReady(ctrlAwReady), .ctrlWReady(ctrlWReady),
    .ctrlBValid(ctrlBValid), .ctrlBReady(ctrlBReady)
  );

  tbMemModel memModel (
    .clk(clk), .reset(reset),
    .faultEnable(faultEnable), .faultAddr(faultAddr), .randomDelay(randomDelay),
    .memReqValid(memReqValid), .memReq(memReq), .memReqReady(memReqReady),
    .memRespValid(memRespValid), .memResp(memResp), .memRespReady(memRespReady)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Parameter register file. The data beat answers the last accepted offset.
  always @(negedge clk)
  begin
    if (paramAddrReady && !paramAddrStop)
      pendingOffset = paramAddrData;
    paramDataReady = !paramDataStop;
    paramDataData  = paramRegs[regIndex(pendingOffset)];
  end

  always @(posedge clk)
  begin
    if (!reset && doneReady && !doneStop)
      doneTransfers++;
  end

  initial
  begin
    cycleCount = 0;
    while (cycleCount < TimeoutCycles)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: the run hung and did not finish within %0d cycles", TimeoutCycles);
    $display(">>> FAIL");
    $finish;
  end

  function automatic int regIndex(regOffsetT offset);
    return int'(offset[7:2]);
  endfunction

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("Fail %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    end
  endtask

  // One kernel run. Checks done, the access count and the result word.
  task automatic runKernel(input string name, input addrT base, input wordT length,
                           input wordT passes, input addrT result, input int holdCycles,
                           output wordT expCount);
    wordT numWords;
    logic faultInside;
    int   expAccesses;
    int   accessesBefore;
    int   doneBefore;

    numWords    = length >> 3;
    faultInside = faultEnable && faultAddr >= base
                  && faultAddr < base + (addrT'(numWords) << 3);
    expCount    = (numWords != 0 && faultInside) ? passes : '0;
    expAccesses = (passes == 0 || numWords == 0) ? 1 : 2 * passes * numWords + 1;

    paramRegs[regIndex(OffsetMemBaseLo)] = base[31:0];
    paramRegs[regIndex(OffsetMemBaseHi)] = base[63:32];
    paramRegs[regIndex(OffsetBlockSize)] = length;
    paramRegs[regIndex(OffsetTestCount)] = passes;
    paramRegs[regIndex(OffsetResultLo)]  = result[31:0];
    paramRegs[regIndex(OffsetResultHi)]  = result[63:32];
    memModel.poke(result, ResultMarker);
    accessesBefore = memModel.reqCount;
    doneBefore     = doneTransfers;

    goReady = 1'b1;
    while (goStop)
      @(negedge clk);
    @(negedge clk);
    goReady = 1'b0;

    while (!doneReady)
      @(negedge clk);
    if (holdCycles > 0)
    begin
      doneStop = 1'b1;
      repeat (holdCycles)
      begin
        @(negedge clk);
        checkValue({name, " done held"}, 1, doneReady);
      end
      doneStop = 1'b0;
    end
    @(negedge clk);
    checkValue({name, " done count"}, 1, doneTransfers - doneBefore);
    checkValue({name, " accesses"}, expAccesses, memModel.reqCount - accessesBefore);
    checkValue({name, " result word"}, dataT'(expCount), memModel.peek(result));
    lastCount = expCount;
  endtask

  task automatic readCtrlCount(input string name);
    slaveReadT value;

    ctrlArValid = 1'b1;
    while (!ctrlArReady)
      @(negedge clk);
    @(negedge clk);
    ctrlArValid = 1'b0;
    while (!ctrlRValid)
      @(negedge clk);
    value      = ctrlRead;
    ctrlRReady = 1'b1;
    @(negedge clk);
    ctrlRReady = 1'b0;
    checkValue({name, " ctrl read"}, lastCount, value.data);
    checkValue({name, " ctrl resp"}, 0, value.resp);
  endtask

  task automatic runClean();
    wordT expCount;

    faultEnable = 1'b0;
    runKernel("runClean", 64'h0000_0001_0000_0100, 32'd128, 32'd3,
              64'h0000_0001_0000_1F00, 0, expCount);
    readCtrlCount("runClean");
  endtask

  task automatic runFaulty();
    wordT expCount;

    faultEnable = 1'b1;
    faultAddr   = 64'h0000_0001_0000_0128;
    runKernel("runFaulty", 64'h0000_0001_0000_0100, 32'd128, 32'd4,
              64'h0000_0001_0000_1F00, 0, expCount);
    readCtrlCount("runFaulty");
  endtask

  task automatic runFaultOutside();
    wordT expCount;
    addrT base;
    addrT addr;

    base        = 64'h0000_0001_0000_0400;
    faultEnable = 1'b1;
    faultAddr   = base + 64'd128;
    runKernel("runFaultOutside", base, 32'd128, 32'd2, 64'h0000_0001_0000_1F00, 0, expCount);
    // Last pass was pass 1.
    for (int i = 0; i < 16; i++)
    begin
      addr = base + 64'(i) * 8;
      checkValue("runFaultOutside pattern", addr ^ PatternStep, memModel.peek(addr));
    end
  endtask

  task automatic runZero();
    wordT expCount;

    faultEnable = 1'b0;
    runKernel("runZero passes", 64'h0000_0000_0000_0600, 32'd128, 32'd0,
              64'h0000_0000_0000_1E80, 0, expCount);
    runKernel("runZero length", 64'h0000_0000_0000_0600, 32'd0, 32'd2,
              64'h0000_0000_0000_1E80, 0, expCount);
  endtask

  task automatic runBackPressure();
    wordT expCount;
    wordT numWords;
    wordT length;
    wordT passes;
    addrT base;

    numWords    = 1 + $urandom % 24;
    length      = numWords * 8 + $urandom % 8;
    passes      = 1 + $urandom % 4;
    base        = 64'h0000_0002_0000_0800;
    faultEnable = 1'b1;
    faultAddr   = base + addrT'($urandom % numWords) * 8;
    randomDelay = 1'b1;
    runKernel("runBackPressure", base, length, passes, 64'h0000_0002_0000_1E00, 6, expCount);
    randomDelay = 1'b0;
    readCtrlCount("runBackPressure");
  endtask

  task automatic ctrlWriteIgnored();
    ctrlAwValid = 1'b1;
    ctrlWValid  = 1'b1;
    while (!(ctrlAwReady && ctrlWReady))
      @(negedge clk);
    @(negedge clk);
    ctrlAwValid = 1'b0;
    ctrlWValid  = 1'b0;
    while (!ctrlBValid)
      @(negedge clk);
    ctrlBReady = 1'b1;
    @(negedge clk);
    ctrlBReady = 1'b0;
    checkValue("ctrlWriteIgnored bValid released", 0, ctrlBValid);
    readCtrlCount("ctrlWriteIgnored");
  endtask

  initial
  begin
    void'($urandom(32'ha2c57545));
    errors         = 0;
    checks         = 0;
    doneTransfers  = 0;
    lastCount      = '0;
    reset          = 1'b1;
    goReady        = 1'b0;
    doneStop       = 1'b0;
    paramAddrStop  = 1'b0;
    paramDataReady = 1'b0;
    paramDataData  = '0;
    ctrlArValid    = 1'b0;
    ctrlRReady     = 1'b0;
    ctrlAwValid    = 1'b0;
    ctrlWValid     = 1'b0;
    ctrlBReady     = 1'b0;
    faultEnable    = 1'b0;
    faultAddr      = '0;
    randomDelay    = 1'b0;
    pendingOffset  = OffsetMemBaseLo;
    for (int i = 0; i < 64; i++)
      paramRegs[i] = '0;

    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    runClean();
    runFaulty();
    runFaultOutside();
    runZero();
    runBackPressure();
    ctrlWriteIgnored();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
memTestPkg.sv
memBusPkg.sv
paramFetcher.sv
patternTester.sv
statusWriter.sv
memArbiter.sv
ctrlSlaveLoopback.sv
memTestAction.sv
tbMemModel.sv
tbMemTestAction.sv

/* Bender.yml */
package:
  name: memTestAction

sources:
  - memTestPkg.sv
  - memBusPkg.sv
  - paramFetcher.sv
  - patternTester.sv
  - statusWriter.sv
  - memArbiter.sv
  - ctrlSlaveLoopback.sv
  - memTestAction.sv
  - target: test
    files:
      - tbMemModel.sv
      - tbMemTestAction.sv
